// ==== include/rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Dispatch, broadcast and retire width
`define SS_SIZE 2

`define NUM_ARCH_REG 32
`define NUM_PHYS_REG 64

// Arch register that always reads as zero
`define ZERO_REG 31

// Never allocated, always ready
`define DUMMY_TAG 63

`define FREE_DEPTH (`NUM_PHYS_REG - `NUM_ARCH_REG)

`endif

// ==== hw/rename_pkg.sv ====
package rename_pkg;

`include "rename_macros.svh"

	typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_reg_t;
	typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_tag_t;

	// One map entry, tag in the upper bits and ready in bit 0
	typedef struct packed {
		phys_tag_t tag;
		logic      ready;
	} map_row_t;

	// Map contents right after reset
	function automatic map_row_t reset_row(input int unsigned idx);
		map_row_t row;
		if (idx == `ZERO_REG) begin
			row.tag = phys_tag_t'(`DUMMY_TAG);
		end else begin
			row.tag = phys_tag_t'(idx);
		end
		row.ready = 1'b1;  // Every initial mapping holds a committed value
		return row;
	endfunction

endpackage

// ==== hw/tag_cam.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module tag_cam #(
	parameter int LENGTH = `NUM_ARCH_REG
) (
	input  rename_pkg::phys_tag_t [LENGTH-1:0]   table_in,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0] tags,
	input  logic [`SS_SIZE-1:0]                  enable,
	output logic [LENGTH-1:0]                    hits
);

	// One comparator per entry and broadcast port
	always_comb begin
		for (int i = 0; i < LENGTH; i++) begin
			hits[i] = 1'b0;
			for (int j = 0; j < `SS_SIZE; j++) begin
				if (enable[j] && (tags[j] == table_in[i])) begin
					hits[i] = 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/map_table.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module map_table (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  logic [`SS_SIZE-1:0]                                    dispatch_en,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]                   src_a,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]                   src_b,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]                   dest,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]                   alloc_tag,
	input  logic                                                   rename_stall,
	input  logic [`SS_SIZE-1:0]                                    cdb_en,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]                   cdb_tag,
	input  logic                                                   branch_incorrect,
	input  rename_pkg::map_row_t [`NUM_ARCH_REG-1:0]               saved_map,
	output rename_pkg::map_row_t [`SS_SIZE-1:0]                    tag_a,
	output rename_pkg::map_row_t [`SS_SIZE-1:0]                    tag_b,
	output rename_pkg::phys_tag_t [`SS_SIZE-1:0]                   tag_old,
	output rename_pkg::map_row_t [`SS_SIZE-1:0][`NUM_ARCH_REG-1:0] map_next
);

	import rename_pkg::*;

	localparam map_row_t DUMMY_ROW = '{tag: phys_tag_t'(`DUMMY_TAG), ready: 1'b1};

	map_row_t [`NUM_ARCH_REG-1:0]  map_q;
	map_row_t [`NUM_ARCH_REG-1:0]  work;
	phys_tag_t [`NUM_ARCH_REG-1:0] cam_table;
	logic [`NUM_ARCH_REG-1:0]      cam_hits;
	logic [`SS_SIZE-1:0]           rename_go;

	always_comb begin
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			cam_table[i] = map_q[i].tag;
		end
	end

	tag_cam #(
		.LENGTH(`NUM_ARCH_REG)
	) u_cam (
		.table_in(cam_table),
		.tags    (cdb_tag),
		.enable  (cdb_en),
		.hits    (cam_hits)
	);

	always_comb begin
		work = map_q;

		// Results on the bus this cycle are visible to this cycle's lookups
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			if (cam_hits[i]) begin
				work[i].ready = 1'b1;
			end
		end

		// Oldest slot first so slot 1 sees slot 0's new mapping
		for (int s = 0; s < `SS_SIZE; s++) begin
			tag_a[s] = (src_a[s] == arch_reg_t'(`ZERO_REG)) ? DUMMY_ROW : work[src_a[s]];
			tag_b[s] = (src_b[s] == arch_reg_t'(`ZERO_REG)) ? DUMMY_ROW : work[src_b[s]];
			if (dest[s] == arch_reg_t'(`ZERO_REG)) begin
				tag_old[s] = phys_tag_t'(`DUMMY_TAG);
			end else begin
				tag_old[s] = work[dest[s]].tag;
			end

			rename_go[s] = dispatch_en[s] && !rename_stall && !branch_incorrect &&
				(dest[s] != arch_reg_t'(`ZERO_REG));
			if (rename_go[s]) begin
				work[dest[s]].tag   = alloc_tag[s];
				work[dest[s]].ready = 1'b0;  // Producer not yet executed
			end

			// State as of the end of this slot, snapshot source for the checkpoint
			map_next[s] = branch_incorrect ? saved_map : work;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				map_q[i] <= reset_row(i);
			end
		end else begin
			map_q <= map_next[`SS_SIZE-1];
		end
	end

endmodule

// ==== hw/free_list.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module free_list (
	input  logic                                            clock,
	input  logic                                            reset,
	input  logic [`SS_SIZE-1:0]                             dispatch_en,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]            dest,
	input  logic [`SS_SIZE-1:0]                             retire_en,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]            retire_tag,
	input  logic                                            branch_incorrect,
	input  logic [$clog2(`FREE_DEPTH)-1:0]                  saved_head,
	output rename_pkg::phys_tag_t [`SS_SIZE-1:0]            alloc_tag,
	output logic                                            rename_stall,
	output logic [`SS_SIZE-1:0][$clog2(`FREE_DEPTH)-1:0]    head_next
);

	import rename_pkg::*;

	localparam int PTR_W = $clog2(`FREE_DEPTH);
	localparam int CNT_W = $clog2(`FREE_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;

	phys_tag_t             queue [`FREE_DEPTH];
	ptr_t                  head;
	ptr_t                  tail;
	ptr_t                  hp;
	ptr_t                  tp;
	ptr_t [`SS_SIZE-1:0]   push_ptr;
	logic [`SS_SIZE-1:0]   pop;
	logic [`SS_SIZE-1:0]   push;
	logic [CNT_W-1:0]      count;
	logic [CNT_W-1:0]      count_next;
	logic [CNT_W-1:0]      pops;
	logic [CNT_W-1:0]      pushes;
	logic [CNT_W-1:0]      back;

	// Pointer step with wrap at the queue end
	function automatic ptr_t ptr_inc(input ptr_t p);
		if (p == ptr_t'(`FREE_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign rename_stall = (count < CNT_W'(`SS_SIZE));

	always_comb begin
		hp   = head;
		pops = '0;
		for (int s = 0; s < `SS_SIZE; s++) begin
			alloc_tag[s] = queue[hp];  // Skipped slots leave the tag to the next one
			pop[s] = dispatch_en[s] && !rename_stall && !branch_incorrect &&
				(dest[s] != arch_reg_t'(`ZERO_REG));
			if (pop[s]) begin
				hp   = ptr_inc(hp);
				pops = pops + 1'b1;
			end
			head_next[s] = branch_incorrect ? saved_head : hp;
		end
	end

	always_comb begin
		tp     = tail;
		pushes = '0;
		for (int s = 0; s < `SS_SIZE; s++) begin
			push_ptr[s] = tp;
			push[s]     = retire_en[s] && (retire_tag[s] != phys_tag_t'(`DUMMY_TAG));
			if (push[s]) begin
				tp     = ptr_inc(tp);
				pushes = pushes + 1'b1;
			end
		end
	end

	// Tags popped since the checkpoint go back on recovery
	always_comb begin
		if (head >= saved_head) begin
			back = CNT_W'(head - saved_head);
		end else begin
			back = CNT_W'(`FREE_DEPTH) - CNT_W'(saved_head) + CNT_W'(head);
		end
		if (branch_incorrect) begin
			count_next = count + pushes + back;
		end else begin
			count_next = count + pushes - pops;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= CNT_W'(`FREE_DEPTH);
			for (int k = 0; k < `FREE_DEPTH; k++) begin
				queue[k] <= phys_tag_t'(`NUM_ARCH_REG - 1 + k);  // Tags 31 to 62
			end
		end else begin
			head  <= head_next[`SS_SIZE-1];
			tail  <= tp;
			count <= count_next;
			for (int s = 0; s < `SS_SIZE; s++) begin
				if (push[s]) begin
					queue[push_ptr[s]] <= retire_tag[s];
				end
			end
		end
	end

endmodule

// ==== hw/branch_checkpoint.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module branch_checkpoint (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  logic                                                   branch_dispatch,
	input  logic [$clog2(`SS_SIZE)-1:0]                            branch_slot,
	input  rename_pkg::map_row_t [`SS_SIZE-1:0][`NUM_ARCH_REG-1:0] map_next,
	input  logic [`SS_SIZE-1:0][$clog2(`FREE_DEPTH)-1:0]           head_next,
	input  logic [`SS_SIZE-1:0]                                    cdb_en,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]                   cdb_tag,
	output rename_pkg::map_row_t [`NUM_ARCH_REG-1:0]               saved_map,
	output logic [$clog2(`FREE_DEPTH)-1:0]                         saved_head
);

	import rename_pkg::*;

	phys_tag_t [`NUM_ARCH_REG-1:0] cam_table;
	logic [`NUM_ARCH_REG-1:0]      cam_hits;

	always_comb begin
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			cam_table[i] = saved_map[i].tag;
		end
	end

	tag_cam #(
		.LENGTH(`NUM_ARCH_REG)
	) u_cam (
		.table_in(cam_table),
		.tags    (cdb_tag),
		.enable  (cdb_en),
		.hits    (cam_hits)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				saved_map[i] <= reset_row(i);
			end
			saved_head <= '0;
		end else if (branch_dispatch) begin
			// Renames up to and including the branch slot
			saved_map  <= map_next[branch_slot];
			saved_head <= head_next[branch_slot];
		end else begin
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				if (cam_hits[i]) begin
					saved_map[i].ready <= 1'b1;  // Keep completed results across a restore
				end
			end
		end
	end

endmodule

// ==== hw/rename_stage.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_stage (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [`SS_SIZE-1:0]                   dispatch_en,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]  src_a,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]  src_b,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0]  dest,
	input  logic [`SS_SIZE-1:0]                   cdb_en,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]  cdb_tag,
	input  logic [`SS_SIZE-1:0]                   retire_en,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0]  retire_tag,
	input  logic                                  branch_dispatch,
	input  logic [$clog2(`SS_SIZE)-1:0]           branch_slot,
	input  logic                                  branch_incorrect,
	output rename_pkg::map_row_t [`SS_SIZE-1:0]   tag_a,
	output rename_pkg::map_row_t [`SS_SIZE-1:0]   tag_b,
	output rename_pkg::phys_tag_t [`SS_SIZE-1:0]  tag_old,
	output rename_pkg::phys_tag_t [`SS_SIZE-1:0]  alloc_tag,
	output logic                                  rename_stall
);

	import rename_pkg::*;

	map_row_t [`SS_SIZE-1:0][`NUM_ARCH_REG-1:0] map_next;
	map_row_t [`NUM_ARCH_REG-1:0]               saved_map;
	logic [`SS_SIZE-1:0][$clog2(`FREE_DEPTH)-1:0] head_next;
	logic [$clog2(`FREE_DEPTH)-1:0]             saved_head;

	map_table u_map (
		.clock           (clock),
		.reset           (reset),
		.dispatch_en     (dispatch_en),
		.src_a           (src_a),
		.src_b           (src_b),
		.dest            (dest),
		.alloc_tag       (alloc_tag),
		.rename_stall    (rename_stall),
		.cdb_en          (cdb_en),
		.cdb_tag         (cdb_tag),
		.branch_incorrect(branch_incorrect),
		.saved_map       (saved_map),
		.tag_a           (tag_a),
		.tag_b           (tag_b),
		.tag_old         (tag_old),
		.map_next        (map_next)
	);

	free_list u_free (
		.clock           (clock),
		.reset           (reset),
		.dispatch_en     (dispatch_en),
		.dest            (dest),
		.retire_en       (retire_en),
		.retire_tag      (retire_tag),
		.branch_incorrect(branch_incorrect),
		.saved_head      (saved_head),
		.alloc_tag       (alloc_tag),
		.rename_stall    (rename_stall),
		.head_next       (head_next)
	);

	// Single snapshot, taken when the branch dispatches
	branch_checkpoint u_ckpt (
		.clock          (clock),
		.reset          (reset),
		.branch_dispatch(branch_dispatch),
		.branch_slot    (branch_slot),
		.map_next       (map_next),
		.head_next      (head_next),
		.cdb_en         (cdb_en),
		.cdb_tag        (cdb_tag),
		.saved_map      (saved_map),
		.saved_head     (saved_head)
	);

endmodule

// ==== bench/rename_checker.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_checker (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [`SS_SIZE-1:0]                  dispatch_en,
	input  rename_pkg::arch_reg_t [`SS_SIZE-1:0] dest,
	input  rename_pkg::phys_tag_t [`SS_SIZE-1:0] alloc_tag,
	input  logic                                 rename_stall,
	input  logic [`SS_SIZE-1:0]                  retire_en,
	input  logic                                 branch_incorrect
);

	import rename_pkg::*;

	int fail_count = 0;  // Read by the testbench at the end of the run
	logic [`SS_SIZE-1:0] pop;

	// Slots that take a tag this cycle
	always_comb begin
		for (int s = 0; s < `SS_SIZE; s++) begin
			pop[s] = dispatch_en[s] && !rename_stall && !branch_incorrect &&
				(dest[s] != arch_reg_t'(`ZERO_REG));
		end
	end

	for (genvar s = 0; s < `SS_SIZE; s++) begin : g_slot
		a_no_dummy: assert property (@(posedge clock) disable iff (reset)
			pop[s] |-> alloc_tag[s] != phys_tag_t'(`DUMMY_TAG))
			else begin
				$error("Slot %0d allocated the dummy tag", s);
				fail_count++;
			end
		if (s > 0) begin : g_pair
			a_distinct: assert property (@(posedge clock) disable iff (reset)
				(pop[s] && pop[s-1]) |-> alloc_tag[s] != alloc_tag[s-1])
				else begin
					$error("Slots %0d and %0d got the same tag", s - 1, s);
					fail_count++;
				end
		end
	end

	// No pop, no push and no restore leaves the queue head alone
	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		(rename_stall && $past(rename_stall) && ~|$past(retire_en) && !$past(branch_incorrect))
		|-> $stable(alloc_tag))
		else begin
			$error("alloc_tag moved while stalled");
			fail_count++;
		end

	a_reset_free: assert property (@(posedge clock) $fell(reset) |-> !rename_stall)
		else begin
			$error("Stall is high right after reset");
			fail_count++;
		end

endmodule

// ==== bench/rename_tb.sv ====
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_tb;

	import rename_pkg::*;

	logic clock;
	logic reset;
	logic [`SS_SIZE-1:0] dispatch_en;
	arch_reg_t [`SS_SIZE-1:0] src_a;
	arch_reg_t [`SS_SIZE-1:0] src_b;
	arch_reg_t [`SS_SIZE-1:0] dest;
	logic [`SS_SIZE-1:0] cdb_en;
	phys_tag_t [`SS_SIZE-1:0] cdb_tag;
	logic [`SS_SIZE-1:0] retire_en;
	phys_tag_t [`SS_SIZE-1:0] retire_tag;
	logic branch_dispatch;
	logic [$clog2(`SS_SIZE)-1:0] branch_slot;
	logic branch_incorrect;
	map_row_t [`SS_SIZE-1:0] tag_a;
	map_row_t [`SS_SIZE-1:0] tag_b;
	phys_tag_t [`SS_SIZE-1:0] tag_old;
	phys_tag_t [`SS_SIZE-1:0] alloc_tag;
	logic rename_stall;

	// Reference model: live map, checkpoint copy and free queue
	phys_tag_t m_tag [`NUM_ARCH_REG];
	logic      m_rdy [`NUM_ARCH_REG];
	phys_tag_t s_tag [`NUM_ARCH_REG];
	logic      s_rdy [`NUM_ARCH_REG];
	phys_tag_t free_q[$];
	phys_tag_t since_ckpt[$];  // Popped after the last branch
	phys_tag_t t_old_q[$];     // T_old in program order, as a ROB would hold them
	int errors;

	rename_stage DUT (.*);

	bind rename_stage rename_checker u_chk (
		.clock           (clock),
		.reset           (reset),
		.dispatch_en     (dispatch_en),
		.dest            (dest),
		.alloc_tag       (alloc_tag),
		.rename_stall    (rename_stall),
		.retire_en       (retire_en),
		.branch_incorrect(branch_incorrect)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			$display("ERR %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	function automatic map_row_t model_row(input arch_reg_t r);
		map_row_t row;
		row.tag   = (r == arch_reg_t'(`ZERO_REG)) ? phys_tag_t'(`DUMMY_TAG) : m_tag[r];
		row.ready = (r == arch_reg_t'(`ZERO_REG)) ? 1'b1 : m_rdy[r];
		return row;
	endfunction

	task automatic timeout_error(input string what);
		$display("Timeout while waiting for %s", what);
		errors++;
	endtask

	task automatic next_cycle();
		@(negedge clock);
		dispatch_en      = '0;
		src_a            = '0;
		src_b            = '0;
		dest             = '0;
		cdb_en           = '0;
		cdb_tag          = '0;
		retire_en        = '0;
		retire_tag       = '0;
		branch_dispatch  = 1'b0;
		branch_slot      = '0;
		branch_incorrect = 1'b0;
	endtask

	// Compare this cycle's outputs, advance the model, step past the clock edge
	task automatic check_cycle();
		logic stall_exp;
		phys_tag_t old_exp;
		map_row_t row_exp;
		#10;
		stall_exp = (free_q.size() < `SS_SIZE);
		expect_eq("rename_stall", rename_stall, stall_exp);
		for (int j = 0; j < `SS_SIZE; j++) begin
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				if (cdb_en[j] && m_tag[i] == cdb_tag[j]) m_rdy[i] = 1'b1;
				if (cdb_en[j] && !branch_dispatch && s_tag[i] == cdb_tag[j]) s_rdy[i] = 1'b1;
			end
		end
		for (int s = 0; s < `SS_SIZE; s++) begin
			expect_eq($sformatf("tag_a[%0d]", s), tag_a[s], model_row(src_a[s]));
			expect_eq($sformatf("tag_b[%0d]", s), tag_b[s], model_row(src_b[s]));
			row_exp = model_row(dest[s]);
			old_exp = row_exp.tag;
			expect_eq($sformatf("tag_old[%0d]", s), tag_old[s], old_exp);
			if (dispatch_en[s] && !stall_exp && !branch_incorrect &&
				dest[s] != arch_reg_t'(`ZERO_REG)) begin
				expect_eq($sformatf("alloc_tag[%0d]", s), alloc_tag[s], free_q[0]);
				m_tag[dest[s]] = free_q.pop_front();
				m_rdy[dest[s]] = 1'b0;
				since_ckpt.push_back(m_tag[dest[s]]);
				t_old_q.push_back(old_exp);
			end
			if (branch_dispatch && branch_slot == s) begin
				s_tag = m_tag;
				s_rdy = m_rdy;
				since_ckpt.delete();
			end
		end
		for (int j = 0; j < `SS_SIZE; j++) begin
			if (retire_en[j] && retire_tag[j] != phys_tag_t'(`DUMMY_TAG)) begin
				free_q.push_back(retire_tag[j]);
			end
		end
		if (branch_incorrect) begin
			m_tag = s_tag;
			m_rdy = s_rdy;
			for (int k = since_ckpt.size() - 1; k >= 0; k--) free_q.push_front(since_ckpt[k]);
			since_ckpt.delete();
		end
		@(posedge clock);
		#1;
	endtask

	task automatic rand_pair();
		dispatch_en = '1;
		for (int s = 0; s < `SS_SIZE; s++) begin
			src_a[s] = arch_reg_t'($urandom_range(`NUM_ARCH_REG - 1));
			src_b[s] = arch_reg_t'($urandom_range(`NUM_ARCH_REG - 1));
			dest[s]  = arch_reg_t'($urandom_range(`NUM_ARCH_REG - 2));  // Never ZERO_REG
		end
	endtask

	task automatic retire_two();
		for (int s = 0; s < `SS_SIZE; s++) begin
			retire_en[s]  = 1'b1;
			retire_tag[s] = t_old_q.pop_front();
		end
	endtask

	// Four lookups per cycle cover the whole map
	task automatic read_all();
		for (int c = 0; c < `NUM_ARCH_REG / 4; c++) begin
			next_cycle();
			for (int s = 0; s < `SS_SIZE; s++) begin
				src_a[s] = arch_reg_t'(4 * c + 2 * s);
				src_b[s] = arch_reg_t'(4 * c + 2 * s + 1);
			end
			check_cycle();
		end
	endtask

	task automatic report_test(input int num, input string name, input int base);
		$display("Test %0d %s: %0d errors", num, name, errors - base);
	endtask

	initial begin
		int base;
		int n;
		arch_reg_t r;
		phys_tag_t first_after;
		void'($urandom(32'hb607_ef4d));
		errors = 0;
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			m_tag[i] = (i == `ZERO_REG) ? phys_tag_t'(`DUMMY_TAG) : phys_tag_t'(i);
			m_rdy[i] = 1'b1;
		end
		s_tag = m_tag;
		s_rdy = m_rdy;
		for (int k = 0; k < `FREE_DEPTH; k++) free_q.push_back(phys_tag_t'(31 + k));
		reset = 1'b1;
		dispatch_en = '0;
		src_a = '0;
		src_b = '0;
		dest = '0;
		cdb_en = '0;
		cdb_tag = '0;
		retire_en = '0;
		retire_tag = '0;
		branch_dispatch = 1'b0;
		branch_slot = '0;
		branch_incorrect = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		base = errors;
		read_all();
		report_test(1, "reset state", base);

		base = errors;
		for (int c = 0; c < 6; c++) begin
			next_cycle();
			rand_pair();
			check_cycle();
		end
		next_cycle();
		rand_pair();
		src_a[1] = dest[0];  // Slot 1 reads slot 0's fresh tag
		src_b[1] = dest[0];
		r = dest[0];
		check_cycle();
		report_test(2, "dispatch", base);

		base = errors;
		next_cycle();
		cdb_en[0]  = 1'b1;
		cdb_tag[0] = m_tag[r];
		src_a[0]   = r;
		check_cycle();
		next_cycle();
		src_a[0] = r;
		check_cycle();
		report_test(3, "broadcast", base);

		base = errors;
		n = 0;
		while (rename_stall !== 1'b1) begin
			if (n == 40) begin
				timeout_error("rename_stall to rise");
				break;
			end
			next_cycle();
			rand_pair();
			check_cycle();
			n++;
		end
		repeat (3) begin
			next_cycle();
			check_cycle();
		end
		n = 0;
		while (rename_stall !== 1'b0) begin
			if (n == 8) begin
				timeout_error("rename_stall to fall");
				break;
			end
			next_cycle();
			retire_two();
			check_cycle();
			n++;
		end
		repeat (4) begin
			next_cycle();
			retire_two();
			check_cycle();
		end
		next_cycle();
		rand_pair();
		check_cycle();
		report_test(4, "retire and stall", base);

		base = errors;
		next_cycle();
		rand_pair();
		branch_dispatch = 1'b1;
		branch_slot = '0;
		r = dest[0];
		check_cycle();
		first_after = since_ckpt[0];
		repeat (2) begin
			next_cycle();
			rand_pair();
			check_cycle();
		end
		next_cycle();
		cdb_en[0]  = 1'b1;
		cdb_tag[0] = s_tag[r];  // Completes a rename that the snapshot holds
		check_cycle();
		next_cycle();
		branch_incorrect = 1'b1;
		check_cycle();
		read_all();
		next_cycle();
		rand_pair();
		#5;
		expect_eq("alloc_tag[0]", alloc_tag[0], first_after);  // First tag popped after the branch
		check_cycle();
		report_test(5, "recovery", base);

		$display("Errors: %0d from checks, %0d from assertions", errors, DUT.u_chk.fail_count);
		if (errors + DUT.u_chk.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hw/rename_pkg.sv
hw/tag_cam.sv
hw/map_table.sv
hw/free_list.sv
hw/branch_checkpoint.sv
hw/rename_stage.sv
bench/rename_checker.sv
bench/rename_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
